//--- include/fetch_settings.svh
// fetch front end settings
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// width of fetch addresses and pc
`define FETCH_ADDR_W 32

// first fetch address after reset
`define FETCH_RESET_PC 32'h8000_0000

// reads allowed in flight on the bus
// kept a power of two so queue pointers wrap on their own
`define FETCH_MAX_PENDING 2

`endif

//--- rtl/fetch_pkg.sv
// fetch front end types
`include "fetch_settings.svh"

package fetch_pkg;

	// base opcodes of the supported subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_JALR = 3'b000;

	// loads and stores
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	// op-imm, shifts share funct3 with a funct7 qualifier
	localparam logic [2:0] F3_ADDI  = 3'b000;
	localparam logic [2:0] F3_SLLI  = 3'b001;
	localparam logic [2:0] F3_SLTI  = 3'b010;
	localparam logic [2:0] F3_SLTIU = 3'b011;
	localparam logic [2:0] F3_XORI  = 3'b100;
	localparam logic [2:0] F3_SRXI  = 3'b101;
	localparam logic [2:0] F3_ORI   = 3'b110;
	localparam logic [2:0] F3_ANDI  = 3'b111;
	localparam logic [6:0] F7_BASE  = 7'b0000000;
	localparam logic [6:0] F7_ALT   = 7'b0100000;

	// system
	localparam logic [2:0]  F3_CSRRW    = 3'b001;
	localparam logic [2:0]  F3_CSRRS    = 3'b010;
	localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET   = 32'h3020_0073;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fields_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fields_t;

	// one instruction word, two decode views
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} inst_word_u;

	typedef struct packed {
		logic                     valid;
		logic [`FETCH_ADDR_W-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] addr;
	} rd_req_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} rd_rsp_t;

	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] pc;
		logic [31:0]              inst;
		logic                     illegal;
		logic                     fault;
	} fetch_out_t;

endpackage

//--- rtl/pc_gen.sv
// fetch program counter
`include "fetch_settings.svh"

module pc_gen import fetch_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  redirect_t                redirect_i,
	input  logic                     ar_fire_i,
	output logic [`FETCH_ADDR_W-1:0] pc_o
);

	localparam logic [`FETCH_ADDR_W-1:0] PC_STEP = 4;

	logic [`FETCH_ADDR_W-1:0] pc_q;
	logic [`FETCH_ADDR_W-1:0] pc_d;

	// redirect wins over sequential step
	// on a coincident accept the old pc already went out on the bus
	always_comb begin
		pc_d = pc_q;
		if (redirect_i.valid) begin
			pc_d = redirect_i.target;
		end else if (ar_fire_i) begin
			pc_d = pc_q + PC_STEP;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= `FETCH_RESET_PC;
		end else begin
			pc_q <= pc_d;
		end
	end

	// address of the next read request
	assign pc_o = pc_q;

endmodule

//--- rtl/fetch_bus.sv
// instruction read channel master
`include "fetch_settings.svh"

module fetch_bus import fetch_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`FETCH_ADDR_W-1:0] pc_i,
	output rd_req_t                  ar_o,
	output logic                     ar_valid_o,
	input  logic                     ar_ready_i,
	output logic                     ar_fire_o,
	input  rd_rsp_t                  r_i,
	input  logic                     r_valid_i,
	output logic                     r_ready_o,
	input  logic                     slot_free_i,
	output logic                     beat_valid_o,
	output logic [`FETCH_ADDR_W-1:0] beat_pc_o,
	output rd_rsp_t                  beat_rsp_o
);

	localparam int DEPTH = `FETCH_MAX_PENDING;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	// addresses accepted but not yet answered, oldest at rd_ptr
	logic [`FETCH_ADDR_W-1:0] pend_pc_q [DEPTH];
	logic [PTR_W-1:0]         wr_ptr_q;
	logic [PTR_W-1:0]         rd_ptr_q;
	logic [CNT_W-1:0]         cnt_q;
	logic [CNT_W-1:0]         cnt_d;
	logic                     ar_valid_q;
	logic                     push;
	logic                     pop;

	// request address tracks the pc register
	assign ar_o.addr  = pc_i;
	assign ar_valid_o = ar_valid_q;
	assign ar_fire_o  = ar_valid_q & ar_ready_i;
	assign push       = ar_fire_o;

	// take data only with something pending and room downstream
	assign r_ready_o = slot_free_i & (cnt_q != '0);
	assign pop       = r_valid_i & r_ready_o;

	assign beat_valid_o = pop;
	assign beat_pc_o    = pend_pc_q[rd_ptr_q];
	assign beat_rsp_o   = r_i;

	always_comb begin
		cnt_d = cnt_q;
		if (push && !pop) begin
			cnt_d = cnt_q + 1'b1;
		end else if (pop && !push) begin
			cnt_d = cnt_q - 1'b1;
		end
	end

	// valid comes from next count, so a raised request always has a free entry
	// and stays up while waiting for ready
	always_ff @(posedge clk) begin
		if (rst) begin
			ar_valid_q <= 1'b0;
			cnt_q      <= '0;
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
		end else begin
			ar_valid_q <= (cnt_d < CNT_W'(DEPTH));
			cnt_q      <= cnt_d;
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			pend_pc_q[wr_ptr_q] <= pc_i;
		end
	end

endmodule

//--- rtl/inst_check.sv
// instruction legality check
`include "fetch_settings.svh"

module inst_check import fetch_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     beat_valid_i,
	input  logic [`FETCH_ADDR_W-1:0] beat_pc_i,
	input  rd_rsp_t                  beat_rsp_i,
	output logic                     slot_free_o,
	output fetch_out_t               out_o,
	output logic                     out_valid_o,
	input  logic                     out_ready_i
);

	inst_word_u word;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;
	logic       fault;
	fetch_out_t out_q;
	logic       valid_q;

	assign word   = beat_rsp_i.data;
	assign opcode = word.r_fields.opcode;
	assign funct3 = word.i_fields.funct3;
	// top imm bits of a shift, read through the r-type view
	assign funct7 = word.r_fields.funct7;

	always_comb begin
		legal = 1'b0;
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_BRANCH, OPC_OP: legal = 1'b1;
			OPC_JALR:  legal = (funct3 == F3_JALR);
			OPC_LOAD:  legal = funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
			OPC_STORE: legal = funct3 inside {F3_SB, F3_SH, F3_SW};
			OPC_OP_IMM: begin
				case (funct3)
					F3_SLLI: legal = (funct7 == F7_BASE);
					F3_SRXI: legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
					default: legal = 1'b1;
				endcase
			end
			OPC_SYSTEM: begin
				legal = (funct3 inside {F3_CSRRW, F3_CSRRS}) ||
					(beat_rsp_i.data inside {INST_ECALL, INST_EBREAK, INST_MRET});
			end
			default: legal = 1'b0;
		endcase
	end

	// bus error overrides decode
	assign fault = (beat_rsp_i.resp != 2'b00);

	// one-entry output slot
	assign slot_free_o = ~valid_q | out_ready_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (beat_valid_i) begin
			valid_q <= 1'b1;
		end else if (out_ready_i) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_valid_i) begin
			out_q.pc      <= beat_pc_i;
			out_q.inst    <= beat_rsp_i.data;
			out_q.illegal <= ~legal & ~fault;
			out_q.fault   <= fault;
		end
	end

	assign out_o       = out_q;
	assign out_valid_o = valid_q;

endmodule

//--- rtl/fetch_top.sv
// instruction fetch front end
`include "fetch_settings.svh"

module fetch_top import fetch_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  redirect_t  redirect_i,
	output rd_req_t    ar_o,
	output logic       ar_valid_o,
	input  logic       ar_ready_i,
	input  rd_rsp_t    r_i,
	input  logic       r_valid_i,
	output logic       r_ready_o,
	output fetch_out_t out_o,
	output logic       out_valid_o,
	input  logic       out_ready_i
);

	logic [`FETCH_ADDR_W-1:0] next_pc;
	logic                     ar_fire;
	logic                     slot_free;
	logic                     beat_valid;
	logic [`FETCH_ADDR_W-1:0] beat_pc;
	rd_rsp_t                  beat_rsp;

	pc_gen u_pc_gen (
		.clk        (clk),
		.rst        (rst),
		.redirect_i (redirect_i),
		.ar_fire_i  (ar_fire),
		.pc_o       (next_pc)
	);

	fetch_bus u_fetch_bus (
		.clk          (clk),
		.rst          (rst),
		.pc_i         (next_pc),
		.ar_o         (ar_o),
		.ar_valid_o   (ar_valid_o),
		.ar_ready_i   (ar_ready_i),
		.ar_fire_o    (ar_fire),
		.r_i          (r_i),
		.r_valid_i    (r_valid_i),
		.r_ready_o    (r_ready_o),
		.slot_free_i  (slot_free),
		.beat_valid_o (beat_valid),
		.beat_pc_o    (beat_pc),
		.beat_rsp_o   (beat_rsp)
	);

	// classified word to decode
	inst_check u_inst_check (
		.clk          (clk),
		.rst          (rst),
		.beat_valid_i (beat_valid),
		.beat_pc_i    (beat_pc),
		.beat_rsp_i   (beat_rsp),
		.slot_free_o  (slot_free),
		.out_o        (out_o),
		.out_valid_o  (out_valid_o),
		.out_ready_i  (out_ready_i)
	);

endmodule

//--- testbench/fetch_assertions.sv
// fetch front end protocol assertions
`include "fetch_settings.svh"

module fetch_assertions import fetch_pkg::*; (
	input logic       clk,
	input logic       rst,
	input redirect_t  redirect_i,
	input rd_req_t    ar_i,
	input logic       ar_valid_i,
	input logic       ar_ready_i,
	input logic       r_valid_i,
	input logic       r_ready_i,
	input fetch_out_t out_i,
	input logic       out_valid_i,
	input logic       out_ready_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// reads accepted and not yet answered
	int pending_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending_q <= 0;
		end else begin
			pending_q <= pending_q + int'(ar_valid_i && ar_ready_i)
				- int'(r_valid_i && r_ready_i);
		end
	end

	pending_limit: assert property (@(posedge clk) disable iff (rst)
		pending_q <= `FETCH_MAX_PENDING)
		else $error("more than %0d reads pending", `FETCH_MAX_PENDING);

	r_ready_needs_read: assert property (@(posedge clk) disable iff (rst)
		r_ready_i |-> pending_q > 0)
		else $error("read data accepted with no read pending");

	ar_valid_hold: assert property (@(posedge clk) disable iff (rst)
		ar_valid_i && !ar_ready_i |=> ar_valid_i)
		else $error("read request dropped before it was accepted");

	// only a redirect may move a waiting address
	ar_addr_steady: assert property (@(posedge clk) disable iff (rst)
		ar_valid_i && !ar_ready_i && !redirect_i.valid |=> $stable(ar_i))
		else $error("read address changed while waiting");

	out_steady: assert property (@(posedge clk) disable iff (rst)
		out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_i))
		else $error("stalled fetch output changed");

	reset_idle: assert property (@(posedge clk)
		rst |=> !ar_valid_i && !r_ready_i && !out_valid_i)
		else $error("handshake outputs not idle after reset");

endmodule

//--- testbench/fetch_tb.sv
// fetch front end testbench
`include "fetch_settings.svh"

module fetch_tb import fetch_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_OUTPUTS = 300;
	// about 6.7 cycles per word leaves room for stalls and bus delays
	localparam int MAX_CYCLES  = NUM_OUTPUTS * 20 / 3;
	localparam int MEM_WORDS   = 256;
	localparam logic [6:0] OPCODES [10] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
		OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_SYSTEM};

	logic       clk;
	logic       rst;
	redirect_t  redirect;
	rd_req_t    ar;
	logic       ar_valid;
	logic       ar_ready;
	rd_rsp_t    r;
	logic       r_valid;
	logic       r_ready;
	fetch_out_t out;
	logic       out_valid;
	logic       out_ready;

	logic [31:0]              mem_words [MEM_WORDS];
	logic [31:0]              pc_q [$];
	rd_rsp_t                  rsp_q [$];
	fetch_out_t               want_q [$];
	logic [`FETCH_ADDR_W-1:0] exp_next_pc;
	logic                     ar_fired;
	logic                     r_fired;
	logic                     held_valid;
	fetch_out_t               held_out;
	int                       stall_left;
	int                       outputs;
	int                       cycles;

	fetch_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.redirect_i  (redirect),
		.ar_o        (ar),
		.ar_valid_o  (ar_valid),
		.ar_ready_i  (ar_ready),
		.r_i         (r),
		.r_valid_i   (r_valid),
		.r_ready_o   (r_ready),
		.out_o       (out),
		.out_valid_o (out_valid),
		.out_ready_i (out_ready)
	);

	bind fetch_top fetch_assertions u_assertions (
		.clk         (clk),
		.rst         (rst),
		.redirect_i  (redirect_i),
		.ar_i        (ar_o),
		.ar_valid_i  (ar_valid_o),
		.ar_ready_i  (ar_ready_i),
		.r_valid_i   (r_valid_i),
		.r_ready_i   (r_ready_o),
		.out_i       (out_o),
		.out_valid_i (out_valid_o),
		.out_ready_i (out_ready_i)
	);

	// legality of the supported subset, taken from raw bit fields
	function automatic logic is_legal(logic [31:0] w);
		logic [2:0] f3;
		logic [6:0] f7;
		logic       legal;
		f3 = w[14:12];
		f7 = w[31:25];
		case (w[6:0])
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_OP, OPC_BRANCH: legal = 1'b1;
			OPC_JALR:  legal = (f3 == 3'b000);
			OPC_LOAD:  legal = (f3 != 3'b011) && (f3 < 3'b110);
			OPC_STORE: legal = (f3 <= 3'b010);
			OPC_OP_IMM: begin
				if (f3 == 3'b001) begin
					legal = (f7 == 7'b0000000);
				end else if (f3 == 3'b101) begin
					legal = (f7 == 7'b0000000) || (f7 == 7'b0100000);
				end else begin
					legal = 1'b1;
				end
			end
			OPC_SYSTEM: legal = (f3 == 3'b001) || (f3 == 3'b010) ||
				(w == INST_ECALL) || (w == INST_EBREAK) || (w == INST_MRET);
			default: legal = 1'b0;
		endcase
		return legal;
	endfunction

	// mix of legal encodings, near misses and raw random words
	function automatic logic [31:0] make_word();
		logic [31:0] w;
		w = $urandom;
		case ($urandom % 8)
			0: begin
				w[6:0]   = OPC_OP_IMM;
				w[14:12] = ($urandom % 2 != 0) ? F3_SLLI : F3_SRXI;
				if ($urandom % 3 == 0) begin
					w[31:25] = F7_BASE;
				end else if ($urandom % 2 == 0) begin
					w[31:25] = F7_ALT;
				end
			end
			1: begin
				case ($urandom % 4)
					0: w = INST_ECALL;
					1: w = INST_EBREAK;
					2: w = INST_MRET;
					default: w[6:0] = OPC_SYSTEM;
				endcase
			end
			2, 3, 4, 5: w[6:0] = OPCODES[4'($urandom % 10)];
			default: w = w;
		endcase
		return w;
	endfunction

	task automatic stop_on_failure();
		$display("tests failed");
		$fatal(1, "fetch testbench stopped at the first error");
	endtask

	task automatic check_equal(input string what, input logic [65:0] expected,
			input logic [65:0] actual);
		if (expected !== actual) begin
			$display("Mismatch at %0t ns: %s, expected %h, got %h", $time, what,
				expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic drive_inputs();
		ar_ready        = ($urandom % 4 != 0);
		redirect.valid  = ($urandom % 20 == 0);
		redirect.target = `FETCH_RESET_PC + (($urandom % MEM_WORDS) << 2);
		// a response stays on the bus until taken
		if (!r_valid || r_fired) begin
			if (rsp_q.size() > 0 && $urandom % 4 != 0) begin
				r_valid = 1'b1;
				r       = rsp_q[0];
			end else begin
				r_valid = 1'b0;
				r       = '0;
			end
		end
		// decode back-pressure with occasional long stalls
		if (stall_left > 0) begin
			out_ready  = 1'b0;
			stall_left = stall_left - 1;
		end else if ($urandom % 40 == 0) begin
			out_ready  = 1'b0;
			stall_left = 8 + int'($urandom % 32);
		end else begin
			out_ready = ($urandom % 8 != 0);
		end
	endtask

	// handshakes that complete on the coming rising edge
	task automatic observe_cycle();
		rd_rsp_t    rsp;
		fetch_out_t want;
		ar_fired = ar_valid && ar_ready;
		r_fired  = r_valid && r_ready;
		if (held_valid) begin
			check_equal("output valid during stall", 66'(1), 66'(out_valid));
			check_equal("output during stall", held_out, out);
		end
		held_valid = out_valid && !out_ready;
		held_out   = out;
		if (ar_fired) begin
			check_equal("accepted address", 66'(exp_next_pc), 66'(ar.addr));
			rsp.data = mem_words[ar.addr[9:2]];
			rsp.resp = ($urandom % 16 == 0) ? 2'b10 : 2'b00;
			rsp_q.push_back(rsp);
			pc_q.push_back(ar.addr);
			exp_next_pc = exp_next_pc + 32'd4;
		end
		// target wins even over an acceptance in the same cycle
		if (redirect.valid) begin
			exp_next_pc = redirect.target;
		end
		if (r_fired) begin
			rsp          = rsp_q.pop_front();
			want.pc      = pc_q.pop_front();
			want.inst    = rsp.data;
			want.fault   = (rsp.resp != 2'b00);
			want.illegal = !want.fault && !is_legal(rsp.data);
			want_q.push_back(want);
		end
		if (out_valid && out_ready) begin
			if (want_q.size() == 0) begin
				$display("decode received a word that memory never returned");
				stop_on_failure();
			end
			check_equal("fetch output", want_q.pop_front(), out);
			outputs++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	initial begin
		void'($urandom(32'h1d28d54c));
		rst         = 1'b1;
		redirect    = '0;
		ar_ready    = 1'b0;
		r           = '0;
		r_valid     = 1'b0;
		out_ready   = 1'b0;
		ar_fired    = 1'b0;
		r_fired     = 1'b0;
		held_valid  = 1'b0;
		held_out    = '0;
		stall_left  = 0;
		outputs     = 0;
		cycles      = 0;
		exp_next_pc = `FETCH_RESET_PC;
		foreach (mem_words[i]) begin
			mem_words[i] = make_word();
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (outputs < NUM_OUTPUTS) begin
			drive_inputs();
			#2;
			observe_cycle();
			@(negedge clk);
			cycles++;
			if (cycles >= MAX_CYCLES) begin
				$display("timeout after %0d cycles with %0d of %0d words delivered",
					cycles, outputs, NUM_OUTPUTS);
				stop_on_failure();
			end
		end
		$display("all tests passed");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/fetch_bus.sv
rtl/inst_check.sv
rtl/fetch_top.sv
testbench/fetch_assertions.sv
testbench/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := fetch_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
